// ==== logic/dma_geom_pkg.sv ====
// Bus geometry defaults for the packet writer and the rule that places
// a packet inside its memory slot
package dma_geom_pkg;

  //////////////////////////////////////////////////////////////////////
  // Default bus geometry
  //////////////////////////////////////////////////////////////////////

  // Width of the stream data and of one memory word
  localparam int DEF_DATA_WIDTH = 64;
  // Byte address width of the packet memory
  localparam int DEF_ADDR_WIDTH = 16;
  // Number of source ports that can show up on tuser
  localparam int DEF_PORT_COUNT = 4;
  // Width of the byte counter that ends up in the descriptor
  localparam int DEF_LEN_WIDTH  = 16;
  // Address bits below the slot number, so each slot is 256 bytes
  localparam int DEF_SLOT_SHIFT = 8;

  //////////////////////////////////////////////////////////////////////
  // Slot address rule
  //////////////////////////////////////////////////////////////////////

  // A packet starts at (slot << SLOT_SHIFT) + HDR_OFFSET
  // The two spare bytes leave the payload 4-byte aligned after an Ethernet header
  localparam int HDR_OFFSET = 2;

endpackage

// ==== logic/recv_desc_pkg.sv ====
// Layout of the 64-bit receive descriptor that the writer hands out
// once a packet is fully stored
package recv_desc_pkg;

  // Whole descriptor width
  localparam int DESC_WIDTH = 64;

  //////////////////////////////////////////////////////////////////////
  // Field positions
  //////////////////////////////////////////////////////////////////////

  // Start byte address of the packet sits in the upper word
  localparam int DESC_ADDR_LSB = 32;
  // Source port taken from tuser on the first beat
  localparam int DESC_PORT_LSB = 24;
  // Slot number taken from tdest on the first beat
  localparam int DESC_SLOT_LSB = 16;
  // Byte count of the packet in the low bits
  localparam int DESC_LEN_LSB  = 0;

  //////////////////////////////////////////////////////////////////////
  // Field widths
  //////////////////////////////////////////////////////////////////////

  // Narrower design fields are zero extended up to these widths
  localparam int DESC_ADDR_BITS = 16;
  localparam int DESC_PORT_BITS = 8;
  localparam int DESC_SLOT_BITS = 8;
  localparam int DESC_LEN_BITS  = 16;

endpackage

// ==== logic/pkt_capture.sv ====
module pkt_capture import dma_geom_pkg::*; #(
  parameter int DATA_WIDTH = 64,
  parameter int ADDR_WIDTH = 16,
  parameter int PORT_COUNT = 4,
  parameter int SLOT_SHIFT = 8
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [DATA_WIDTH-1:0]   s_data,
  input  logic [DATA_WIDTH/8-1:0] s_keep,
  input  logic                    s_valid,
  input  logic                    s_last,
  input  logic [ADDR_WIDTH-SLOT_SHIFT-1:0] s_dest,
  input  logic [$clog2(PORT_COUNT)-1:0]    s_user,
  input  logic                    write_fire,
  input  logic                    desc_blocked,
  output logic                    s_ready,
  output logic [DATA_WIDTH-1:0]   stage_data,
  output logic [DATA_WIDTH/8-1:0] stage_strb,
  output logic                    wr_en_lvl,
  output logic                    first_word,
  output logic                    last_word,
  output logic [$clog2(DATA_WIDTH/8):0]    offset,
  output logic [ADDR_WIDTH-1:0]   aligned_start,
  output logic [ADDR_WIDTH-1:0]   start_addr,
  output logic [$clog2(PORT_COUNT)-1:0]    port,
  output logic [ADDR_WIDTH-SLOT_SHIFT-1:0] slot
);

  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int SHIFT_BITS = $clog2(STRB_WIDTH);

  typedef enum logic {
    ST_IDLE,
    ST_PKT
  } cap_state_t;

  cap_state_t              state;
  logic                    beat;
  logic                    latch_info;
  logic                    stage_last;
  logic                    strb_left;
  logic                    extra_cycle;
  logic                    extra_cycle_r;
  logic [ADDR_WIDTH-1:0]   first_addr;
  logic [SHIFT_BITS:0]     first_offset;

  //////////////////////////////////////////////////////////////////////
  // Start address and realignment offset of a new packet
  //////////////////////////////////////////////////////////////////////

  // Slot number selects the upper address bits
  assign first_addr   = {s_dest, {SLOT_SHIFT{1'b0}}} + ADDR_WIDTH'(HDR_OFFSET);
  // Offset is how far the pair of stages is shifted down to land on a word
  assign first_offset = (SHIFT_BITS+1)'(STRB_WIDTH) - {1'b0, first_addr[SHIFT_BITS-1:0]};

  assign beat = s_valid && s_ready;
  // A new packet starts from idle or right behind the last word of the previous one
  assign latch_info = ((state == ST_IDLE) || (last_word && write_fire)) && beat;

  // The last beat needs one more word when its bytes spill past the offset
  assign extra_cycle = stage_last && strb_left;
  // The final word is either the last beat itself or the tail behind it
  assign last_word   = wr_en_lvl && ((stage_last && !extra_cycle) || extra_cycle_r);

  // Accept while stage one is free or leaving this cycle
  // The last beat waits while an older descriptor is still pending
  assign s_ready = (!wr_en_lvl || write_fire) && !extra_cycle && !(s_last && desc_blocked);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else if (beat) begin
      state <= ST_PKT;
    end else if (last_word && write_fire) begin
      state <= ST_IDLE;
    end
  end

  // Metadata of the packet for the address generator and the descriptor
  always_ff @(posedge clk) begin
    if (latch_info) begin
      start_addr <= first_addr;
      offset     <= first_offset;
      slot       <= s_dest;
      port       <= s_user;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stage one and write enable
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_strb    <= '0;
      stage_last    <= 1'b0;
      strb_left     <= 1'b0;
      extra_cycle_r <= 1'b0;
    end else begin
      // The tail word drains stage two only, so stage one is emptied
      if (extra_cycle && write_fire) begin
        stage_strb <= '0;
        stage_last <= 1'b0;
        strb_left  <= 1'b0;
      end else if (beat) begin
        stage_strb <= s_keep;
        stage_last <= s_last;
        strb_left  <= |(s_keep >> (latch_info ? first_offset : offset));
      end
      if (write_fire) begin
        extra_cycle_r <= extra_cycle;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat) begin
      stage_data <= s_data;
    end
  end

  // Enable stays up while a word waits or while the tail is still owed
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_en_lvl  <= 1'b0;
      first_word <= 1'b0;
    end else begin
      wr_en_lvl  <= beat || (write_fire && extra_cycle) || (wr_en_lvl && !write_fire);
      first_word <= latch_info || (first_word && !write_fire);
    end
  end

  assign aligned_start = {start_addr[ADDR_WIDTH-1:SHIFT_BITS], {SHIFT_BITS{1'b0}}};

  // A presented word and the stage one contents behind it stay put until memory takes it
  a_wr_en_hold: assert property (@(posedge clk) disable iff (rst)
    wr_en_lvl && !write_fire |=> wr_en_lvl && $stable(stage_data) && $stable(stage_strb));

endmodule

// ==== logic/byte_realign.sv ====
module byte_realign #(
  parameter int DATA_WIDTH = 64,
  parameter int ADDR_WIDTH = 16
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [DATA_WIDTH-1:0]   stage_data,
  input  logic [DATA_WIDTH/8-1:0] stage_strb,
  input  logic                    wr_en_lvl,
  input  logic                    first_word,
  input  logic                    last_word,
  input  logic [$clog2(DATA_WIDTH/8):0] offset,
  input  logic [ADDR_WIDTH-1:0]   aligned_start,
  input  logic                    mem_wr_ready,
  output logic                    mem_wr_en,
  output logic [ADDR_WIDTH-1:0]   mem_wr_addr,
  output logic [DATA_WIDTH-1:0]   mem_wr_data,
  output logic [DATA_WIDTH/8-1:0] mem_wr_strb,
  output logic                    mem_wr_last,
  output logic                    write_fire
);

  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  logic [DATA_WIDTH-1:0] prev_data;
  logic [STRB_WIDTH-1:0] prev_strb;
  logic [ADDR_WIDTH-1:0] next_addr;

  // A word leaves when memory is ready for it
  assign write_fire = wr_en_lvl && mem_wr_ready;

  //////////////////////////////////////////////////////////////////////
  // Stage two
  //////////////////////////////////////////////////////////////////////

  // Stage two trails stage one by one accepted word
  always_ff @(posedge clk) begin
    if (write_fire) begin
      prev_data <= stage_data;
    end
  end

  // Its strobes are cleared after the final word
  // so the first word of the next packet has nothing below the header offset
  always_ff @(posedge clk) begin
    if (rst) begin
      prev_strb <= '0;
    end else if (last_word && write_fire) begin
      prev_strb <= '0;
    end else if (write_fire) begin
      prev_strb <= stage_strb;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Realigned word and address
  //////////////////////////////////////////////////////////////////////

  // The low bytes come from the older word and the rest from the newer one
  assign mem_wr_data = DATA_WIDTH'({stage_data, prev_data} >> {offset, 3'b000});
  assign mem_wr_strb = STRB_WIDTH'({stage_strb, prev_strb} >> offset);

  // Running word address for every write after the first
  always_ff @(posedge clk) begin
    if (write_fire) begin
      next_addr <= mem_wr_addr + ADDR_WIDTH'(STRB_WIDTH);
    end
  end

  assign mem_wr_addr = first_word ? aligned_start : next_addr;
  assign mem_wr_en   = wr_en_lvl;
  assign mem_wr_last = last_word;

  // Memory sees the same word until it takes it
  a_wr_stable: assert property (@(posedge clk) disable iff (rst)
    mem_wr_en && !mem_wr_ready |=>
      $stable(mem_wr_addr) && $stable(mem_wr_data) && $stable(mem_wr_strb));

endmodule

// ==== logic/recv_desc_gen.sv ====
module recv_desc_gen import recv_desc_pkg::*; #(
  parameter int DATA_WIDTH = 64,
  parameter int ADDR_WIDTH = 16,
  parameter int PORT_COUNT = 4,
  parameter int LEN_WIDTH  = 16,
  parameter int SLOT_SHIFT = 8
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [DATA_WIDTH/8-1:0] mem_wr_strb,
  input  logic                    mem_wr_last,
  input  logic                    write_fire,
  input  logic [ADDR_WIDTH-1:0]   start_addr,
  input  logic [$clog2(PORT_COUNT)-1:0]    port,
  input  logic [ADDR_WIDTH-SLOT_SHIFT-1:0] slot,
  input  logic                    recv_desc_ready,
  output logic                    recv_desc_valid,
  output logic [DESC_WIDTH-1:0]   recv_desc,
  output logic                    desc_blocked
);

  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int SHIFT_BITS = $clog2(STRB_WIDTH);

  logic [SHIFT_BITS:0]    byte_count;
  logic [LEN_WIDTH-1:0]   pkt_len;
  logic [LEN_WIDTH-1:0]   next_len;
  logic                   new_pkt;
  logic [DESC_WIDTH-1:0]  desc_next;

  //////////////////////////////////////////////////////////////////////
  // Byte counting
  //////////////////////////////////////////////////////////////////////

  // Strobes may have holes at either end after realignment
  always_comb begin
    byte_count = '0;
    for (int i = 0; i < STRB_WIDTH; i++) begin
      byte_count = byte_count + (SHIFT_BITS+1)'(mem_wr_strb[i]);
    end
  end

  assign next_len = new_pkt ? LEN_WIDTH'(byte_count) : pkt_len + LEN_WIDTH'(byte_count);

  // The word after a fired last word starts a fresh count
  always_ff @(posedge clk) begin
    if (rst) begin
      new_pkt <= 1'b1;
    end else if (write_fire) begin
      new_pkt <= mem_wr_last;
    end
  end

  always_ff @(posedge clk) begin
    if (write_fire) begin
      pkt_len <= next_len;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Descriptor register
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    desc_next = '0;
    desc_next[DESC_ADDR_LSB +: DESC_ADDR_BITS] = DESC_ADDR_BITS'(start_addr);
    desc_next[DESC_PORT_LSB +: DESC_PORT_BITS] = DESC_PORT_BITS'(port);
    desc_next[DESC_SLOT_LSB +: DESC_SLOT_BITS] = DESC_SLOT_BITS'(slot);
    desc_next[DESC_LEN_LSB +: DESC_LEN_BITS]   = DESC_LEN_BITS'(next_len);
  end

  // The capture stage holds back a last beat while this is full
  // so a fired last word always finds the register free
  always_ff @(posedge clk) begin
    if (rst) begin
      recv_desc_valid <= 1'b0;
    end else if (write_fire && mem_wr_last) begin
      recv_desc_valid <= 1'b1;
    end else if (recv_desc_ready) begin
      recv_desc_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (write_fire && mem_wr_last) begin
      recv_desc <= desc_next;
    end
  end

  // A descriptor is pending from the cycle its last word fires until it is taken
  // A single-beat packet right behind that word has to wait as well
  assign desc_blocked = (recv_desc_valid && !recv_desc_ready) || (write_fire && mem_wr_last);

  // A pending descriptor is neither dropped nor overwritten
  a_desc_hold: assert property (@(posedge clk) disable iff (rst)
    recv_desc_valid && !recv_desc_ready |=> recv_desc_valid && $stable(recv_desc));

endmodule

// ==== logic/axis_mem_writer.sv ====
module axis_mem_writer import dma_geom_pkg::*, recv_desc_pkg::*; #(
  parameter int DATA_WIDTH = DEF_DATA_WIDTH,
  parameter int ADDR_WIDTH = DEF_ADDR_WIDTH,
  parameter int PORT_COUNT = DEF_PORT_COUNT,
  parameter int LEN_WIDTH  = DEF_LEN_WIDTH,
  parameter int SLOT_SHIFT = DEF_SLOT_SHIFT
) (
  input  logic                    clk,
  input  logic                    rst,
  // Packet stream in
  input  logic [DATA_WIDTH-1:0]   s_axis_tdata,
  input  logic [DATA_WIDTH/8-1:0] s_axis_tkeep,
  input  logic                    s_axis_tvalid,
  output logic                    s_axis_tready,
  input  logic                    s_axis_tlast,
  input  logic [ADDR_WIDTH-SLOT_SHIFT-1:0] s_axis_tdest,
  input  logic [$clog2(PORT_COUNT)-1:0]    s_axis_tuser,
  // Memory write port
  output logic                    mem_wr_en,
  output logic [DATA_WIDTH/8-1:0] mem_wr_strb,
  output logic [ADDR_WIDTH-1:0]   mem_wr_addr,
  output logic [DATA_WIDTH-1:0]   mem_wr_data,
  output logic                    mem_wr_last,
  input  logic                    mem_wr_ready,
  // Receive descriptor out
  output logic                    recv_desc_valid,
  input  logic                    recv_desc_ready,
  output logic [DESC_WIDTH-1:0]   recv_desc
);

  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int SHIFT_BITS = $clog2(STRB_WIDTH);
  localparam int PORT_WIDTH = $clog2(PORT_COUNT);
  localparam int SLOT_WIDTH = ADDR_WIDTH - SLOT_SHIFT;

  // Every design field has to fit its descriptor field
  if (ADDR_WIDTH > DESC_ADDR_BITS) begin : g_addr_chk
    $error("Address width exceeds the descriptor address field");
  end
  if (PORT_WIDTH > DESC_PORT_BITS) begin : g_port_chk
    $error("Port width exceeds the descriptor port field");
  end
  if (SLOT_WIDTH > DESC_SLOT_BITS) begin : g_slot_chk
    $error("Slot width exceeds the descriptor slot field");
  end
  if (LEN_WIDTH > DESC_LEN_BITS) begin : g_len_chk
    $error("Length width exceeds the descriptor length field");
  end

  logic [DATA_WIDTH-1:0] stage_data;
  logic [STRB_WIDTH-1:0] stage_strb;
  logic                  wr_en_lvl;
  logic                  first_word;
  logic                  last_word;
  logic [SHIFT_BITS:0]   offset;
  logic [ADDR_WIDTH-1:0] aligned_start;
  logic [ADDR_WIDTH-1:0] start_addr;
  logic [PORT_WIDTH-1:0] port;
  logic [SLOT_WIDTH-1:0] slot;
  logic                  write_fire;
  logic                  desc_blocked;

  pkt_capture #(
    .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH),
    .PORT_COUNT(PORT_COUNT), .SLOT_SHIFT(SLOT_SHIFT)
  ) u_capture (
    .clk, .rst,
    .s_data(s_axis_tdata), .s_keep(s_axis_tkeep), .s_valid(s_axis_tvalid),
    .s_last(s_axis_tlast), .s_dest(s_axis_tdest), .s_user(s_axis_tuser),
    .write_fire, .desc_blocked, .s_ready(s_axis_tready),
    .stage_data, .stage_strb, .wr_en_lvl, .first_word, .last_word,
    .offset, .aligned_start, .start_addr, .port, .slot
  );

  byte_realign #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) u_realign (
    .clk, .rst, .stage_data, .stage_strb, .wr_en_lvl, .first_word, .last_word,
    .offset, .aligned_start, .mem_wr_ready, .mem_wr_en, .mem_wr_addr,
    .mem_wr_data, .mem_wr_strb, .mem_wr_last, .write_fire
  );

  recv_desc_gen #(
    .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH), .PORT_COUNT(PORT_COUNT),
    .LEN_WIDTH(LEN_WIDTH), .SLOT_SHIFT(SLOT_SHIFT)
  ) u_desc (
    .clk, .rst, .mem_wr_strb, .mem_wr_last, .write_fire, .start_addr, .port,
    .slot, .recv_desc_ready, .recv_desc_valid, .recv_desc, .desc_blocked
  );

endmodule

// ==== test/axis_mem_writer_tb.sv ====
module axis_mem_writer_tb import dma_geom_pkg::*, recv_desc_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DATA_WIDTH = DEF_DATA_WIDTH;
  localparam int ADDR_WIDTH = DEF_ADDR_WIDTH;
  localparam int PORT_COUNT = DEF_PORT_COUNT;
  localparam int LEN_WIDTH  = DEF_LEN_WIDTH;
  localparam int SLOT_SHIFT = DEF_SLOT_SHIFT;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int PORT_WIDTH = $clog2(PORT_COUNT);
  localparam int SLOT_WIDTH = ADDR_WIDTH - SLOT_SHIFT;
  localparam int MEM_BYTES  = 1 << ADDR_WIDTH;
  // About 40 beats at up to 4 cycles each, the 50-cycle stall, reset and lots of margin
  localparam int MAX_CYCLES = 4000;

  logic                  clk = 1'b0;
  logic                  rst;
  logic [DATA_WIDTH-1:0] s_axis_tdata;
  logic [STRB_WIDTH-1:0] s_axis_tkeep;
  logic                  s_axis_tvalid;
  logic                  s_axis_tready;
  logic                  s_axis_tlast;
  logic [SLOT_WIDTH-1:0] s_axis_tdest;
  logic [PORT_WIDTH-1:0] s_axis_tuser;
  logic                  mem_wr_en;
  logic [STRB_WIDTH-1:0] mem_wr_strb;
  logic [ADDR_WIDTH-1:0] mem_wr_addr;
  logic [DATA_WIDTH-1:0] mem_wr_data;
  logic                  mem_wr_last;
  logic                  mem_wr_ready;
  logic                  recv_desc_valid;
  logic                  recv_desc_ready;
  logic [DESC_WIDTH-1:0] recv_desc;

  // Memory written by the DUT and the copy built from the slot rule
  logic [7:0]            mem [MEM_BYTES];
  logic [7:0]            exp_mem [MEM_BYTES];
  logic [DESC_WIDTH-1:0] got_desc [$];
  logic [DESC_WIDTH-1:0] exp_desc [$];
  // Word address that holds the final byte of each packet still in flight
  logic [ADDR_WIDTH-1:0] exp_last [$];
  int                    next_desc;
  logic                  rand_ready;
  logic                  ready_coin;
  int                    cycles = 0;
  int                    checks;
  int                    errors;

  axis_mem_writer #(
    .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH), .PORT_COUNT(PORT_COUNT),
    .LEN_WIDTH(LEN_WIDTH), .SLOT_SHIFT(SLOT_SHIFT)
  ) dut (.*);

  always #5 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Memory model and descriptor sink
  //////////////////////////////////////////////////////////////////////

  // Untouched bytes keep a pattern of their whole address
  function automatic logic [7:0] fill_byte(int addr);
    return 8'(addr) ^ 8'(addr >> 8) ^ 8'h5a;
  endfunction

  // Readiness is either always on or about three cycles in four
  assign mem_wr_ready = !rand_ready || ready_coin;

  always @(negedge clk) begin
    ready_coin <= ($urandom_range(3, 0) != 0);
  end

  always @(posedge clk) begin
    if (rst) begin
      for (int a = 0; a < MEM_BYTES; a++) begin
        mem[a] = fill_byte(a);
      end
    end else if (mem_wr_en && mem_wr_ready) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (mem_wr_strb[b]) begin
          mem[mem_wr_addr + ADDR_WIDTH'(b)] = mem_wr_data[8*b +: 8];
        end
      end
      // The word marked last has to be the one holding the packet's final byte
      if (mem_wr_last) begin
        if (exp_last.size() == 0) begin
          errors++;
          $display("mem_wr_last was set while no packet was in flight");
        end else begin
          check_value("mem_wr_last addr", 64'(mem_wr_addr), 64'(exp_last.pop_front()));
        end
      end
    end
  end

  always @(posedge clk) begin
    if (!rst && recv_desc_valid && recv_desc_ready) begin
      got_desc.push_back(recv_desc);
    end
  end

  // Hard stop in case a handshake never completes
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles, %0d errors so far", cycles, errors);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // Packet contents depend only on a tag, so a packet can be sent again unchanged
  function automatic logic [7:0] pkt_byte(int tag, int n);
    return 8'((tag << 4) ^ (n * 13));
  endfunction

  function automatic logic [DESC_WIDTH-1:0] make_desc(int addr, int port, int slot, int len);
    logic [DESC_WIDTH-1:0] d;
    d = '0;
    d[DESC_ADDR_LSB +: DESC_ADDR_BITS] = DESC_ADDR_BITS'(addr);
    d[DESC_PORT_LSB +: DESC_PORT_BITS] = DESC_PORT_BITS'(port);
    d[DESC_SLOT_LSB +: DESC_SLOT_BITS] = DESC_SLOT_BITS'(slot);
    d[DESC_LEN_LSB +: DESC_LEN_BITS]   = DESC_LEN_BITS'(len);
    return d;
  endfunction

  // Called on a falling edge and returns on the falling edge after the beat is taken
  task automatic send_beat(logic [DATA_WIDTH-1:0] data, logic [STRB_WIDTH-1:0] keep,
                           logic last, int slot, int port);
    logic taken;
    s_axis_tdata  = data;
    s_axis_tkeep  = keep;
    s_axis_tlast  = last;
    s_axis_tdest  = SLOT_WIDTH'(slot);
    s_axis_tuser  = PORT_WIDTH'(port);
    s_axis_tvalid = 1'b1;
    taken = 1'b0;
    while (!taken) begin
      @(posedge clk);
      taken = s_axis_tready;
      @(negedge clk);
    end
    s_axis_tvalid = 1'b0;
  endtask

  // Byte n goes to slot * 2^SLOT_SHIFT + HDR_OFFSET + n
  task automatic send_packet(int slot, int port, int len, int tag);
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] keep;
    int base;
    int beats;
    int n;
    base = (slot << SLOT_SHIFT) + HDR_OFFSET;
    for (int i = 0; i < len; i++) begin
      exp_mem[base + i] = pkt_byte(tag, i);
    end
    exp_desc.push_back(make_desc(base, port, slot, len));
    exp_last.push_back(ADDR_WIDTH'((base + len - 1) & ~(STRB_WIDTH - 1)));
    beats = (len + STRB_WIDTH - 1) / STRB_WIDTH;
    for (int b = 0; b < beats; b++) begin
      data = '0;
      keep = '0;
      for (int k = 0; k < STRB_WIDTH; k++) begin
        n = b * STRB_WIDTH + k;
        if (n < len) begin
          data[8*k +: 8] = pkt_byte(tag, n);
          keep[k] = 1'b1;
        end
      end
      send_beat(data, keep, b == beats - 1, slot, port);
    end
  endtask

  // Waits for every expected descriptor and compares them in arrival order
  task automatic collect_descs();
    while (got_desc.size() < exp_desc.size()) begin
      @(negedge clk);
    end
    while (next_desc < exp_desc.size()) begin
      check_value("recv_desc", got_desc[next_desc], exp_desc[next_desc]);
      next_desc++;
    end
    check_value("recv_desc count", 64'(got_desc.size()), 64'(exp_desc.size()));
  endtask

  // The whole slot is compared so stray strobes show up as well
  task automatic check_slot(int slot);
    int base;
    base = slot << SLOT_SHIFT;
    for (int a = base; a < base + (1 << SLOT_SHIFT); a++) begin
      check_value($sformatf("mem[%h]", a), 64'(mem[a]), 64'(exp_mem[a]));
    end
  endtask

  // Four packets with every slot, port and length different
  task automatic send_set(int slot_base);
    int lens [4] = '{13, 1, 30, 64};
    for (int i = 0; i < 4; i++) begin
      send_packet(slot_base + i, i, lens[i], 10 + i);
    end
    collect_descs();
    for (int i = 0; i < 4; i++) begin
      check_slot(slot_base + i);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_single_beat();
    send_packet(3, 1, 5, 1);
    collect_descs();
    check_slot(3);
  endtask

  // Three full beats at offset 2 leave two bytes for an extra word
  task automatic test_tail_spill();
    send_packet(4, 2, 24, 2);
    collect_descs();
    check_slot(4);
  endtask

  task automatic test_back_to_back();
    send_set(10);
  endtask

  // Same packets as the back-to-back test, into fresh slots
  task automatic test_random_ready();
    rand_ready = 1'b1;
    send_set(20);
    rand_ready = 1'b0;
  endtask

  task automatic test_desc_stall();
    logic second_done;
    second_done = 1'b0;
    recv_desc_ready = 1'b0;
    send_packet(30, 3, 17, 5);
    fork
      begin
        send_packet(31, 0, 21, 6);
        second_done = 1'b1;
      end
      begin
        repeat (50) @(negedge clk);
        // First descriptor still waiting and the second packet's last beat held off
        check_value("second packet done", 64'(second_done), 64'(0));
        check_value("recv_desc_valid", 64'(recv_desc_valid), 64'(1));
        check_value("recv_desc", recv_desc, exp_desc[next_desc]);
        // The earlier beats of the held packet have already reached memory
        for (int k = 0; k < STRB_WIDTH; k++) begin
          check_value($sformatf("mem[%h]", (31 << SLOT_SHIFT) + HDR_OFFSET + k),
                      64'(mem[(31 << SLOT_SHIFT) + HDR_OFFSET + k]), 64'(pkt_byte(6, k)));
        end
        recv_desc_ready = 1'b1;
      end
    join
    collect_descs();
    check_slot(30);
    check_slot(31);
  endtask

  initial begin
    void'($urandom(94));
    checks          = 0;
    errors          = 0;
    next_desc       = 0;
    rand_ready      = 1'b0;
    rst             = 1'b1;
    s_axis_tdata    = '0;
    s_axis_tkeep    = '0;
    s_axis_tvalid   = 1'b0;
    s_axis_tlast    = 1'b0;
    s_axis_tdest    = '0;
    s_axis_tuser    = '0;
    recv_desc_ready = 1'b1;
    for (int a = 0; a < MEM_BYTES; a++) begin
      exp_mem[a] = fill_byte(a);
    end
    repeat (8) @(negedge clk);
    rst = 1'b0;
    // Outputs idle right after reset
    check_value("mem_wr_en", 64'(mem_wr_en), 64'(0));
    check_value("mem_wr_last", 64'(mem_wr_last), 64'(0));
    check_value("recv_desc_valid", 64'(recv_desc_valid), 64'(0));
    test_single_beat();
    test_tail_spill();
    test_back_to_back();
    test_random_ready();
    test_desc_stall();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== axis_mem_writer.f ====
logic/dma_geom_pkg.sv
logic/recv_desc_pkg.sv
logic/pkt_capture.sv
logic/byte_realign.sv
logic/recv_desc_gen.sv
logic/axis_mem_writer.sv
test/axis_mem_writer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module axis_mem_writer_tb -f axis_mem_writer.f -o sim_axis_mem_writer

./obj_dir/sim_axis_mem_writer > sim.log
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
  exit 1
fi
